/* filelist.f */
hdl/transform_pkg.sv
hdl/model_world_stage.sv
hdl/camera_cull_stage.sv
hdl/perspective_projector.sv
hdl/triangle_transformer.sv
test/tb_triangle_transformer.sv

/* hdl/camera_cull_stage.sv */
`timescale 1ns/1ps

module camera_cull_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  transform_pkg::world_tri_t world,
    input  logic                      in_valid,
    output logic                      in_ready,
    output transform_pkg::triangle_t  out_triangle,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic                      busy
);

    import transform_pkg::*;

    triangle_t cam_tri;
    logic      cull;

    function automatic vec3_t sub_vec(input vec3_t a, input vec3_t b);
        vec3_t d;
        d.x = a.x - b.x;
        d.y = a.y - b.y;
        d.z = a.z - b.z;
        return d;
    endfunction

    function automatic logic z_ok(input q16_16_t z);
        return (z >= NEAR_Z) && (z <= FAR_Z);
    endfunction

    always_comb begin
        cam_tri.v0 = sub_vec(world.triangle.v0, world.camera_pos);
        cam_tri.v1 = sub_vec(world.triangle.v1, world.camera_pos);
        cam_tri.v2 = sub_vec(world.triangle.v2, world.camera_pos);
        cull = !(z_ok(cam_tri.v0.z) && z_ok(cam_tri.v1.z) && z_ok(cam_tri.v2.z));
    end

    assign in_ready = !out_valid || out_ready;
    assign busy     = out_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= !cull;  // Culled triangles are consumed and dropped
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready && !cull) begin
            out_triangle <= cam_tri;
        end
    end

    // The projector divides by these depths so they must be positive
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> z_ok(out_triangle.v0.z) && z_ok(out_triangle.v1.z)
                      && z_ok(out_triangle.v2.z));

endmodule

/* hdl/model_world_stage.sv */
`timescale 1ns/1ps

module model_world_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  transform_pkg::transform_setup_t setup,
    input  logic                           in_valid,
    output logic                           in_ready,
    output transform_pkg::world_tri_t      out_world,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic                           busy
);

    import transform_pkg::*;

    world_tri_t world_next;

    function automatic q16_16_t scale_axis(input q16_16_t a, input q16_16_t s);
        logic signed [63:0] prod;
        prod = 64'(a) * 64'(s);
        return q16_16_t'(prod >>> Q_FRAC);
    endfunction

    function automatic vec3_t to_world(input vec3_t v, input vec3_t s, input vec3_t p);
        vec3_t w;
        w.x = scale_axis(v.x, s.x) + p.x;
        w.y = scale_axis(v.y, s.y) + p.y;
        w.z = scale_axis(v.z, s.z) + p.z;
        return w;
    endfunction

    always_comb begin
        world_next.triangle.v0 = to_world(setup.triangle.v0, setup.model_scale, setup.model_pos);
        world_next.triangle.v1 = to_world(setup.triangle.v1, setup.model_scale, setup.model_pos);
        world_next.triangle.v2 = to_world(setup.triangle.v2, setup.model_scale, setup.model_pos);
        world_next.camera_pos  = setup.camera_pos;
    end

    // Register can take a new item when empty or draining on this edge
    assign in_ready = !out_valid || out_ready;
    assign busy     = out_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_world <= world_next;
        end
    end

    // A stalled output must hold both valid and data
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_world));

endmodule

/* hdl/perspective_projector.sv */
`timescale 1ns/1ps

module perspective_projector (
    input  logic                     clk,
    input  logic                     rst_n,
    input  transform_pkg::triangle_t triangle,
    input  logic                     in_valid,
    output logic                     in_ready,
    output transform_pkg::triangle_t screen_tri,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     busy
);

    import transform_pkg::*;

    typedef enum logic [1:0] {IDLE, LOAD, DIVIDE, DONE} state_t;

    state_t     state;
    logic [2:0] coord_idx;  // Which of the six x/y values is being divided
    logic [4:0] bit_cnt;

    triangle_t  tri_reg;
    q16_16_t    res_xy [6];
    logic [32:0] rem;
    logic [31:0] quo;       // Remaining dividend bits in, quotient bits out
    logic [31:0] divisor;
    logic        neg;

    logic [2:0]  load_idx;
    q16_16_t     load_coord;
    logic [31:0] load_mag;
    logic [63:0] dividend;
    logic [32:0] trial;
    logic        q_bit;
    logic [31:0] quo_next;
    q16_16_t     q_signed;
    q16_16_t     screen_val;
    logic        last_bit;

    function automatic q16_16_t pick_coord(input triangle_t t, input logic [2:0] idx);
        case (idx)
            3'd0: return t.v0.x;
            3'd1: return t.v0.y;
            3'd2: return t.v1.x;
            3'd3: return t.v1.y;
            3'd4: return t.v2.x;
            default: return t.v2.y;
        endcase
    endfunction

    function automatic q16_16_t pick_z(input triangle_t t, input logic [2:0] idx);
        case (idx[2:1])
            2'd0: return t.v0.z;
            2'd1: return t.v1.z;
            default: return t.v2.z;
        endcase
    endfunction

    always_comb begin
        load_idx   = (state == LOAD) ? 3'd0 : coord_idx + 3'd1;
        load_coord = pick_coord(tri_reg, load_idx);
        load_mag   = load_coord[31] ? -load_coord : load_coord;
        dividend   = {32'd0, load_mag} << (FOCAL_SHIFT + Q_FRAC);

        // One restoring step
        trial    = {rem[31:0], quo[31]};
        q_bit    = trial >= {1'b0, divisor};
        quo_next = {quo[30:0], q_bit};
        q_signed = neg ? -q16_16_t'(quo_next) : q16_16_t'(quo_next);
        if (coord_idx[0]) begin
            screen_val = q16_16_t'((SCREEN_HEIGHT / 2) << Q_FRAC) - q_signed;  // Y grows downward
        end else begin
            screen_val = q_signed + q16_16_t'((SCREEN_WIDTH / 2) << Q_FRAC);
        end
        last_bit = (state == DIVIDE) && (bit_cnt == 5'd31);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            coord_idx <= 3'd0;
            bit_cnt   <= 5'd0;
        end else begin
            case (state)
                IDLE: if (in_valid) state <= LOAD;
                LOAD: begin
                    state     <= DIVIDE;
                    coord_idx <= 3'd0;
                    bit_cnt   <= 5'd0;
                end
                DIVIDE: begin
                    bit_cnt <= bit_cnt + 5'd1;
                    if (last_bit) begin
                        if (coord_idx == 3'd5) begin
                            state <= DONE;
                        end else begin
                            coord_idx <= coord_idx + 3'd1;
                        end
                    end
                end
                default: if (out_ready) state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            tri_reg <= triangle;
        end
        if (state == LOAD || (last_bit && coord_idx != 3'd5)) begin
            rem     <= {1'b0, dividend[63:32]};
            quo     <= dividend[31:0];
            divisor <= pick_z(tri_reg, load_idx);
            neg     <= load_coord[31];
        end else if (state == DIVIDE) begin
            rem <= q_bit ? trial - {1'b0, divisor} : trial;
            quo <= quo_next;
        end
        if (last_bit) begin
            res_xy[coord_idx] <= screen_val;
        end
    end

    always_comb begin
        screen_tri.v0 = '{x: res_xy[0], y: res_xy[1], z: tri_reg.v0.z};
        screen_tri.v1 = '{x: res_xy[2], y: res_xy[3], z: tri_reg.v1.z};
        screen_tri.v2 = '{x: res_xy[4], y: res_xy[5], z: tri_reg.v2.z};
    end

    assign in_ready  = (state == IDLE);
    assign out_valid = (state == DONE);
    assign busy      = (state != IDLE);

    // No second triangle may enter during the 193 cycles of one projection
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_ready |=> (busy && !in_ready) [*193]);

endmodule

/* hdl/transform_pkg.sv */
package transform_pkg;

    // Signed Q16.16 fixed point
    typedef logic signed [31:0] q16_16_t;

    typedef struct packed {
        q16_16_t x;
        q16_16_t y;
        q16_16_t z;
    } vec3_t;

    typedef struct packed {
        vec3_t v0;
        vec3_t v1;
        vec3_t v2;
    } triangle_t;

    typedef struct packed {
        triangle_t triangle;     // Model-space vertices
        vec3_t     model_scale;  // Per-axis scale of the model
        vec3_t     model_pos;    // Model origin in world space
        vec3_t     camera_pos;   // Camera origin in world space
    } transform_setup_t;

    typedef struct packed {
        triangle_t triangle;     // World-space vertices
        vec3_t     camera_pos;
    } world_tri_t;

    localparam int Q_FRAC        = 16;
    localparam int SCREEN_WIDTH  = 320;
    localparam int SCREEN_HEIGHT = 240;
    localparam int FOCAL_SHIFT   = 8;   // Focal length of 256

    // Depth range kept by the culler
    localparam q16_16_t NEAR_Z = 32'sd65536;
    localparam q16_16_t FAR_Z  = 32'sd65536000;

endpackage

/* hdl/triangle_transformer.sv */
`timescale 1ns/1ps

module triangle_transformer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  transform_pkg::transform_setup_t setup,
    input  logic                            in_valid,
    output logic                            in_ready,
    output transform_pkg::triangle_t        screen_tri,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic                            busy
);

    import transform_pkg::*;

    world_tri_t mw_world;
    logic       mw_valid, mw_ready, mw_busy;

    triangle_t  cc_triangle;
    logic       cc_valid, cc_ready, cc_busy;

    logic       pp_busy;

    model_world_stage u_model_world_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .setup     (setup),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_world (mw_world),
        .out_valid (mw_valid),
        .out_ready (mw_ready),
        .busy      (mw_busy)
    );

    camera_cull_stage u_camera_cull_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .world        (mw_world),
        .in_valid     (mw_valid),
        .in_ready     (mw_ready),
        .out_triangle (cc_triangle),
        .out_valid    (cc_valid),
        .out_ready    (cc_ready),
        .busy         (cc_busy)
    );

    perspective_projector u_perspective_projector (
        .clk        (clk),
        .rst_n      (rst_n),
        .triangle   (cc_triangle),
        .in_valid   (cc_valid),
        .in_ready   (cc_ready),
        .screen_tri (screen_tri),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .busy       (pp_busy)
    );

    assign busy = mw_busy | cc_busy | pp_busy;

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_triangle_transformer \
    -o tb_sim && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Test passed$" sim.log && echo "PASSED" || { echo "FAILED"; exit 1; }

/* test/tb_triangle_transformer.sv */
`timescale 1ns/1ps

module tb_triangle_transformer;

    import transform_pkg::*;

    localparam int FIELDS_PER_VECTOR = 28;
    localparam int RESET_CYCLES      = 8;
    localparam int CYCLES_PER_VECTOR = 300;

    logic             clk;
    logic             rst_n;
    transform_setup_t setup;
    logic             in_valid;
    logic             in_ready;
    triangle_t        screen_tri;
    logic             out_valid;
    logic             out_ready;
    logic             busy;

    transform_setup_t setups [$];
    logic             cull_flags [$];
    triangle_t        expected_tris [$];
    triangle_t        expected_q [$];   // Triangles still to come out, in order
    int               n_vec;
    int               n_expect;
    int               sent;
    int               received;
    logic             vectors_loaded;
    logic [15:0]      lfsr;

    triangle_transformer dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .setup      (setup),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .screen_tri (screen_tri),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .busy       (busy)
    );

    always #4 clk = ~clk;

    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16, 14, 13, 11
    endfunction

    task automatic check_value(input string name, input logic [287:0] expected,
                               input logic [287:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic load_vectors();
        int           fd;
        int           code;
        int           v;
        int           k;
        int           base;
        string        tok;
        string        rest;
        logic [31:0]  word;
        logic [31:0]  words [$];
        logic [575:0] setup_bits;
        logic [287:0] tri_bits;
        fd = $fopen("test/transform_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file test/transform_vectors.txt");
            $display("Test failed");
            $fatal(1);
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok[0] == "#") begin
                code = $fgets(rest, fd);  // Rest of a comment line
            end else begin
                code = $sscanf(tok, "%h", word);
                if (code != 1) begin
                    $display("The vector file holds a field that is not hex: %s", tok);
                    $display("Test failed");
                    $fatal(1);
                end
                words.push_back(word);
            end
        end
        $fclose(fd);
        if (words.size() == 0 || words.size() % FIELDS_PER_VECTOR != 0) begin
            $display("The vector file holds %0d fields, which is not a whole number of vectors",
                     words.size());
            $display("Test failed");
            $fatal(1);
        end
        n_vec = words.size() / FIELDS_PER_VECTOR;
        for (v = 0; v < n_vec; v++) begin
            base = v * FIELDS_PER_VECTOR;
            for (k = 0; k < 18; k++) begin
                setup_bits = {setup_bits[543:0], words[base + k]};
            end
            for (k = 0; k < 9; k++) begin
                tri_bits = {tri_bits[255:0], words[base + 19 + k]};
            end
            word = words[base + 18];
            setups.push_back(transform_setup_t'(setup_bits));
            cull_flags.push_back(word != 32'd0);
            expected_tris.push_back(triangle_t'(tri_bits));
        end
    endtask

    initial begin
        logic in_fire;
        logic drained;
        logic gap_a;
        logic gap_b;
        clk            = 1'b0;
        rst_n          = 1'b0;
        setup          = '0;
        in_valid       = 1'b0;
        out_ready      = 1'b0;
        sent           = 0;
        received       = 0;
        lfsr           = 16'd48;
        vectors_loaded = 1'b0;
        load_vectors();
        for (int v = 0; v < n_vec; v++) begin
            if (!cull_flags[v]) begin
                expected_q.push_back(expected_tris[v]);
            end
        end
        n_expect       = expected_q.size();
        vectors_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("out_valid after reset", 288'(0), 288'(out_valid));
        check_value("busy after reset", 288'(0), 288'(busy));
        check_value("in_ready after reset", 288'(1), 288'(in_ready));

        drained = 1'b0;
        while (!drained) begin
            @(negedge clk);
            in_fire = in_valid && in_ready;
            @(posedge clk);
            #1;
            if (in_fire) begin
                sent++;
            end
            if (!in_valid || in_fire) begin  // A waiting vector stays on the bus
                lfsr  = next_lfsr(lfsr);
                gap_a = lfsr[0];
                lfsr  = next_lfsr(lfsr);
                gap_b = lfsr[0];
                if (sent < n_vec && (gap_a || gap_b)) begin
                    setup    = setups[sent];
                    in_valid = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            lfsr      = next_lfsr(lfsr);
            out_ready = lfsr[0];
            // Ends when all triangles are out or when the DUT goes idle
            drained = (sent == n_vec) && (received == n_expect || !busy);
        end

        out_ready = 1'b1;
        repeat (10) @(posedge clk);  // Room for a duplicate to show up
        #1;
        check_value("output count", 288'(n_expect), 288'(received));
        check_value("busy after drain", 288'(0), 288'(busy));
        $display("Test passed");
        $finish;
    end

    always @(negedge clk) begin
        triangle_t expected;
        if (rst_n && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                $display("A triangle came out after all expected triangles had arrived");
                $display("Test failed");
                $fatal(1);
            end else begin
                expected = expected_q.pop_front();
                check_value($sformatf("screen triangle %0d", received), expected, screen_tri);
                received++;
            end
        end
    end

    initial begin
        wait (vectors_loaded);
        repeat (RESET_CYCLES + CYCLES_PER_VECTOR * n_vec) @(posedge clk);
        $display("The pipeline stalled with %0d of %0d vectors sent and %0d of %0d triangles out",
                 sent, n_vec, received, n_expect);
        $display("Test failed");
        $fatal(1);
    end

endmodule

/* test/transform_vectors.txt */
# Q16.16 hex: triangle v0 xyz v1 xyz v2 xyz, model_scale xyz, model_pos xyz, camera_pos xyz
# Then the cull flag (1 = culled) and the expected screen v0 xyz v1 xyz v2 xyz
00010000 00020000 00040000 FFFD0000 00008000 00040000 00000000 FFFF0000 00040000 00010000 00010000 00010000 00000000 00000000 00000000 00000000 00000000 00000000 0 00E00000 FFF80000 00040000 FFE00000 00580000 00040000 00A00000 00B80000 00040000
00010000 FFFF0000 00030000 FFFE0000 00050000 00030000 FFFF0000 FFFE0000 00030000 00010000 00010000 00010000 00000000 00000000 00000000 00000000 00000000 00000000 0 00F55555 00CD5555 00030000 FFF55556 FECD5556 00030000 004AAAAB 0122AAAA 00030000
00004000 00020000 00000000 FFFD0000 FFFF0000 FFFC0000 00000000 00040000 00000000 00020000 00008000 00018000 00030000 FFFF0000 000A0000 00010000 00010000 00020000 0 00F00000 00980000 00080000 FEA00000 01B80000 00020000 00E00000 00780000 00080000
00010000 00010000 00008000 00020000 00010000 00040000 00010000 00020000 00040000 00010000 00010000 00010000 00000000 00000000 00000000 00000000 00000000 00000000 1 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00010000 00010000 00040000 00020000 00020000 03E88000 00030000 00010000 00040000 00010000 00010000 00010000 00000000 00000000 00000000 00000000 00000000 00000000 1 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00010000 00010000 00010000 FFFE0000 00000000 03E80000 01F40000 FF060000 01F40000 00010000 00010000 00010000 00000000 00000000 00000000 00000000 00000000 00000000 0 01A00000 FF780000 00010000 009F7CEE 00780000 03E80000 01A00000 00F80000 01F40000
00040000 00020000 00000000 FFF80000 FFFC0000 00040000 00000000 FFFFFFFF 000C0000 0000C000 00014000 00010000 00000000 00000000 00030000 FFFE0000 00008000 FFFF0000 0 01E00000 FFF80000 00040000 00200000 01280000 00080000 00C00000 00800020 00100000
00010000 00010000 00040000 00020000 00010000 00040000 00010000 00020000 00040000 00010000 00010000 00010000 00000000 00000000 00000000 00000000 00000000 00050000 1 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00010000 FFFF0000 00030000 FFFE0000 00050000 00030000 FFFF0000 FFFE0000 00030000 00010000 00010000 00010000 00000000 00000000 00000000 00000000 00000000 00000000 0 00F55555 00CD5555 00030000 FFF55556 FECD5556 00030000 004AAAAB 0122AAAA 00030000
